//--- build.f
+incdir+include
src/fpuPkg.sv
src/fpAlign.sv
src/fpMantAdd.sv
src/fpNormalize.sv
src/fpAdder.sv
verification/tbClock.sv
verification/fpAdder_checker.sv
verification/fpAdderTb.sv

//--- include/fpu_consts.svh
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// single precision field layout.
`define FP_WIDTH    32
`define EXP_WIDTH   8
`define MANT_WIDTH  23    // stored fraction bits only.

// biased exponent that encodes infinity.
`define EXP_MAX     255

// hidden bit, fraction, then guard, round and sticky.
`define ALIGN_WIDTH (`MANT_WIDTH + 4)

// one extra bit on top for the carry out of the add.
`define SUM_WIDTH   (`ALIGN_WIDTH + 1)

// enough to count up to ALIGN_WIDTH-1 leading zeros.
`define LZC_WIDTH   5

`endif

//--- src/fpAdder.sv
`timescale 1ns/100ps

module fpAdder
    import fpuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    output logic    inReady,
    input  fpWord_t a,
    input  fpWord_t b,
    output logic    outValid,
    input  logic    outReady,
    output fpWord_t result
);

    // align to add.
    logic         alignValid;
    logic         alignReady;
    fpExp_t       bigExp;
    fpAlignMant_t bigMant;
    fpAlignMant_t smallMant;
    logic         resultSign;
    logic         effSub;

    // add to normalize.
    logic         sumValid;
    logic         sumReady;
    fpExp_t       sumExp;
    fpSumMant_t   sumMant;
    logic         sumSign;

    fpAlign uAlign (
        .clk        (clk),
        .rst        (rst),
        .inValid    (inValid),
        .inReady    (inReady),
        .a          (a),
        .b          (b),
        .alignValid (alignValid),
        .alignReady (alignReady),
        .bigExp     (bigExp),
        .bigMant    (bigMant),
        .smallMant  (smallMant),
        .resultSign (resultSign),
        .effSub     (effSub)
    );

    fpMantAdd uMantAdd (
        .clk        (clk),
        .rst        (rst),
        .alignValid (alignValid),
        .alignReady (alignReady),
        .bigExp     (bigExp),
        .bigMant    (bigMant),
        .smallMant  (smallMant),
        .resultSign (resultSign),
        .effSub     (effSub),
        .sumValid   (sumValid),
        .sumReady   (sumReady),
        .sumExp     (sumExp),
        .sumMant    (sumMant),
        .sumSign    (sumSign)
    );

    fpNormalize uNormalize (
        .clk      (clk),
        .rst      (rst),
        .sumValid (sumValid),
        .sumReady (sumReady),
        .sumExp   (sumExp),
        .sumMant  (sumMant),
        .sumSign  (sumSign),
        .outValid (outValid),
        .outReady (outReady),
        .result   (result)
    );

endmodule

//--- src/fpAlign.sv
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpAlign
    import fpuPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         inValid,
    output logic         inReady,
    input  fpWord_t      a,
    input  fpWord_t      b,
    output logic         alignValid,
    input  logic         alignReady,
    output fpExp_t       bigExp,
    output fpAlignMant_t bigMant,
    output fpAlignMant_t smallMant,
    output logic         resultSign,
    output logic         effSub
);

    logic                      signA;
    logic                      signB;
    fpExp_t                    expA;
    fpExp_t                    expB;
    logic [`MANT_WIDTH:0]      sigA;
    logic [`MANT_WIDTH:0]      sigB;
    logic                      aLarger;
    fpExp_t                    expBig;
    fpExp_t                    expSmall;
    fpExp_t                    expDiff;
    logic [`MANT_WIDTH:0]      sigBig;
    logic [`MANT_WIDTH:0]      sigSmall;
    logic [2*`ALIGN_WIDTH-1:0] shiftWide;
    fpAlignMant_t              alignedSmall;

    assign signA = a[`FP_WIDTH-1];
    assign signB = b[`FP_WIDTH-1];
    assign expA  = a[`FP_WIDTH-2 -: `EXP_WIDTH];
    assign expB  = b[`FP_WIDTH-2 -: `EXP_WIDTH];

    // exponent zero reads as zero, subnormals included.
    assign sigA = (expA == '0) ? '0 : {1'b1, a[`MANT_WIDTH-1:0]};
    assign sigB = (expB == '0) ? '0 : {1'b1, b[`MANT_WIDTH-1:0]};

    // exponent decides first, significand breaks the tie.
    assign aLarger = (expA > expB) || ((expA == expB) && (sigA > sigB));

    assign expBig   = aLarger ? expA : expB;
    assign expSmall = aLarger ? expB : expA;
    assign sigBig   = aLarger ? sigA : sigB;
    assign sigSmall = aLarger ? sigB : sigA;
    assign expDiff  = expBig - expSmall;

    // lower half catches everything shifted past the sticky position.
    assign shiftWide = {sigSmall, 3'b000, {`ALIGN_WIDTH{1'b0}}} >> expDiff;

    always_comb begin
        if (expDiff >= `ALIGN_WIDTH) begin
            alignedSmall = {{(`ALIGN_WIDTH-1){1'b0}}, |sigSmall}; // only sticky left.
        end else begin
            alignedSmall = {shiftWide[2*`ALIGN_WIDTH-1:`ALIGN_WIDTH+1],
                            shiftWide[`ALIGN_WIDTH] | (|shiftWide[`ALIGN_WIDTH-1:0])};
        end
    end

    // register is free when empty or being drained this cycle.
    assign inReady = !alignValid || alignReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            alignValid <= 1'b0;
        end else if (inReady) begin
            alignValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid && inReady) begin
            bigExp     <= expBig;
            bigMant    <= {sigBig, 3'b000};
            smallMant  <= alignedSmall;
            resultSign <= aLarger ? signA : signB;
            effSub     <= signA ^ signB;
        end
    end

endmodule

//--- src/fpMantAdd.sv
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpMantAdd
    import fpuPkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         alignValid,
    output logic         alignReady,
    input  fpExp_t       bigExp,
    input  fpAlignMant_t bigMant,
    input  fpAlignMant_t smallMant,
    input  logic         resultSign,
    input  logic         effSub,
    output logic         sumValid,
    input  logic         sumReady,
    output fpExp_t       sumExp,
    output fpSumMant_t   sumMant,
    output logic         sumSign
);

    fpSumMant_t bigExt;
    fpSumMant_t smallExt;
    fpSumMant_t sumNext;

    // room for the carry on top.
    assign bigExt   = {1'b0, bigMant};
    assign smallExt = {1'b0, smallMant};

    // big is never below small, so the difference cannot go negative.
    always_comb begin
        if (effSub) begin
            sumNext = bigExt - smallExt;
        end else begin
            sumNext = bigExt + smallExt;
        end
    end

    assign alignReady = !sumValid || sumReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            sumValid <= 1'b0;
        end else if (alignReady) begin
            sumValid <= alignValid;
        end
    end

    always_ff @(posedge clk) begin
        if (alignValid && alignReady) begin
            sumExp  <= bigExp;   // exponent of the larger operand.
            sumMant <= sumNext;
            sumSign <= resultSign;
        end
    end

endmodule

//--- src/fpNormalize.sv
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpNormalize
    import fpuPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       sumValid,
    output logic       sumReady,
    input  fpExp_t     sumExp,
    input  fpSumMant_t sumMant,
    input  logic       sumSign,
    output logic       outValid,
    input  logic       outReady,
    output fpWord_t    result
);

    logic         sumZero;
    logic         carryOut;
    fpShift_t     lzCount;
    fpAlignMant_t normMant;
    fpExpWide_t   expExt;
    fpExpWide_t   normExp;
    fpWord_t      resultNext;

    assign sumZero  = (sumMant == '0);
    assign carryOut = sumMant[`SUM_WIDTH-1];
    assign expExt   = fpExpWide_t'({2'b00, sumExp});

    // priority encoder below the carry bit, the highest set bit wins.
    always_comb begin
        lzCount = '0;
        for (int i = 0; i < `ALIGN_WIDTH; i++) begin
            if (sumMant[i]) begin
                lzCount = fpShift_t'(`ALIGN_WIDTH - 1 - i);
            end
        end
    end

    always_comb begin
        if (carryOut) begin
            // one place right, the dropped bit stays in sticky.
            normMant = {sumMant[`SUM_WIDTH-1:2], sumMant[1] | sumMant[0]};
            normExp  = expExt + fpExpWide_t'(1);
        end else begin
            normMant = sumMant[`ALIGN_WIDTH-1:0] << lzCount;
            normExp  = expExt - fpExpWide_t'({{(`EXP_WIDTH+2-`LZC_WIDTH){1'b0}}, lzCount});
        end
    end

    // grs bits are dropped here, which is the truncation.
    always_comb begin
        if (sumZero || (normExp <= 0)) begin
            resultNext = '0;                                    // exact zero or underflow.
        end else if (normExp >= `EXP_MAX) begin
            resultNext = {sumSign, {`EXP_WIDTH{1'b1}}, {`MANT_WIDTH{1'b0}}};
        end else begin
            resultNext = {sumSign, normExp[`EXP_WIDTH-1:0],
                          normMant[`ALIGN_WIDTH-2 -: `MANT_WIDTH]};
        end
    end

    assign sumReady = !outValid || outReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else if (sumReady) begin
            outValid <= sumValid;
        end
    end

    always_ff @(posedge clk) begin
        if (sumValid && sumReady) begin
            result <= resultNext;
        end
    end

endmodule

//--- src/fpuPkg.sv
`include "fpu_consts.svh"

package fpuPkg;

    // full operand or result word.
    typedef logic [`FP_WIDTH-1:0] fpWord_t;

    // biased exponent as stored.
    typedef logic [`EXP_WIDTH-1:0] fpExp_t;

    // significand after alignment, grs bits at the bottom.
    typedef logic [`ALIGN_WIDTH-1:0] fpAlignMant_t;

    // sum or difference of two aligned significands.
    typedef logic [`SUM_WIDTH-1:0] fpSumMant_t;

    // two spare bits so that overflow and underflow stay visible.
    typedef logic signed [`EXP_WIDTH+1:0] fpExpWide_t;

    // normalize shift count.
    typedef logic [`LZC_WIDTH-1:0] fpShift_t;

endpackage

//--- verification/fpAdderTb.sv
`timescale 1ns/100ps
`include "fpu_consts.svh"

module fpAdderTb
    import fpuPkg::*;
();

    typedef struct {
        string   name;
        fpWord_t a;
        fpWord_t b;
        fpWord_t expected;
    } testVector_t;

    localparam int numRandom = 200;

    logic        clk;
    logic        rst;
    logic        inValid;
    logic        inReady;
    fpWord_t     a;
    fpWord_t     b;
    logic        outValid;
    logic        outReady;
    fpWord_t     result;
    testVector_t vectors[$];
    fpWord_t     randA[numRandom];
    fpWord_t     randB[numRandom];
    fpWord_t     expQ[$];
    string       nameQ[$];
    int          sentQ[$];
    bit          timedQ[$];
    integer      seed = 32'hd4d0;
    int          cycleCount = 0;
    int          timeoutLimit = 100;
    int          received = 0;
    bit          timingChecks = 1'b1;
    bit          stallOutput = 1'b0;

    tbClock uClock (.clk(clk), .rst(rst));

    fpAdder DUT (
        .clk(clk), .rst(rst), .inValid(inValid), .inReady(inReady), .a(a), .b(b),
        .outValid(outValid), .outReady(outReady), .result(result)
    );

    bind fpAdder fpAdderChecker uChecker (
        .clk(clk), .rst(rst), .outValid(outValid), .outReady(outReady), .result(result)
    );

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("ERR %s expected %h actual %h", name, expected, actual));
        end
    endtask

    // exact sum in a wide integer, then truncated to 24 significant bits.
    function automatic fpWord_t refAdd(input fpWord_t x, input fpWord_t y);
        logic [299:0] magX;
        logic [299:0] magY;
        logic [299:0] total;
        logic [299:0] shifted;
        int           expX;
        int           expY;
        int           baseExp;
        int           msb;
        int           resExp;
        logic         resSign;
        expX    = x[30:23];
        expY    = y[30:23];
        baseExp = (expX < expY) ? expX : expY;
        magX    = (expX == 0) ? '0 : (300'({1'b1, x[22:0]}) << (expX - baseExp));
        magY    = (expY == 0) ? '0 : (300'({1'b1, y[22:0]}) << (expY - baseExp));
        resSign = (magX >= magY) ? x[31] : y[31];
        if (x[31] == y[31]) begin
            total = magX + magY;
        end else begin
            total = (magX >= magY) ? (magX - magY) : (magY - magX);
        end
        if (total == '0) return '0;
        msb = 0;
        for (int i = 0; i < 300; i++) begin
            if (total[i]) msb = i;
        end
        resExp = baseExp + msb - `MANT_WIDTH;
        if (resExp <= 0) return '0;                 // underflow goes to +0.
        if (resExp >= `EXP_MAX) return {resSign, 8'hff, 23'h0};
        shifted = (msb >= 23) ? (total >> (msb - 23)) : (total << (23 - msb));
        return {resSign, 8'(resExp), shifted[22:0]};
    endfunction

    task automatic addVector(input string name, input fpWord_t x, input fpWord_t y,
                             input fpWord_t expected);
        testVector_t v;
        v.name     = name;
        v.a        = x;
        v.b        = y;
        v.expected = expected;
        vectors.push_back(v);
    endtask

    task automatic loadVectors();
        addVector("carry 1.5+1.5",      32'h3FC00000, 32'h3FC00000, 32'h40400000);
        addVector("small 1+2^-20",      32'h3F800000, 32'h35800000, 32'h3F800008);
        addVector("diff one 2+1",       32'h40000000, 32'h3F800000, 32'h40400000);
        addVector("neg carry",          32'hBFC00000, 32'hBFC00000, 32'hC0400000);
        addVector("cancel 1-(1-ulp)",   32'h3F800000, 32'hBF7FFFFF, 32'h33800000);
        addVector("cancel (1+ulp)-1",   32'h3F800001, 32'hBF800000, 32'h34000000);
        addVector("cancel 1.5-1.25",    32'h3FC00000, 32'hBFA00000, 32'h3E800000);
        addVector("x minus x",          32'h40490FDB, 32'hC0490FDB, 32'h00000000);
        addVector("2-0.5",              32'h40000000, 32'hBF000000, 32'h3FC00000);
        addVector("1-3 negative",       32'h3F800000, 32'hC0400000, 32'hC0000000);
        addVector("far sub 1-2^-30",    32'h3F800000, 32'hB0800000, 32'h3F7FFFFF);
        addVector("far sub 1.5-2^-40",  32'h3FC00000, 32'hAB800000, 32'h3FBFFFFF);
        addVector("far add 1+2^-30",    32'h3F800000, 32'h30800000, 32'h3F800000);
        addVector("zero plus x",        32'h00000000, 32'h40490FDB, 32'h40490FDB);
        addVector("x plus zero",        32'hC0490FDB, 32'h00000000, 32'hC0490FDB);
        addVector("subnormal flush",    32'h00000001, 32'h3F800000, 32'h3F800000);
        addVector("neg zeros",          32'h80000000, 32'h80000000, 32'h00000000);
        addVector("max plus max",       32'h7F7FFFFF, 32'h7F7FFFFF, 32'h7F800000);
        addVector("neg max overflow",   32'hFF7FFFFF, 32'hFF7FFFFF, 32'hFF800000);
        addVector("min normal diff",    32'h00800001, 32'h80800000, 32'h00000000);
        addVector("min normal sum",     32'h00800000, 32'h00800000, 32'h01000000);
    endtask

    // holds the pair until the DUT takes it.
    task automatic sendPair(input string name, input fpWord_t x, input fpWord_t y,
                            input fpWord_t expected);
        inValid <= 1'b1;
        a       <= x;
        b       <= y;
        expQ.push_back(expected);
        nameQ.push_back(name);
        timedQ.push_back(timingChecks);
        @(posedge clk);
        while (!inReady) begin
            if (timingChecks) checkValue({name, " inReady"}, 32'd1, 32'(inReady));
            @(posedge clk);
        end
        sentQ.push_back(cycleCount);
    endtask

    task automatic waitDrained();
        while (expQ.size() != 0) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (stallOutput) outReady <= 1'($random(seed)); // low about half the time.
        else outReady <= 1'b1;
    end

    always @(posedge clk) begin
        string   name;
        fpWord_t expected;
        int      sent;
        bit      timed;
        cycleCount <= cycleCount + 1;
        if (cycleCount > timeoutLimit) stopWithFailure("timeout waiting for the DUT results");
        if (DUT.uChecker.failCount != 0) stopWithFailure("an output handshake assertion failed");
        if (!rst && outValid && outReady) begin
            if (expQ.size() == 0) stopWithFailure("the DUT gave a result with nothing in flight");
            expected = expQ.pop_front();
            name     = nameQ.pop_front();
            sent     = sentQ.pop_front();
            timed    = timedQ.pop_front();
            checkValue(name, expected, result);
            if (timed) checkValue({name, " latency"}, 32'd3, 32'(cycleCount - sent));
            received++;
        end
    end

    initial begin
        int randExpA;
        int randExpB;
        inValid  = 1'b0;
        a        = '0;
        b        = '0;
        outReady = 1'b1;
        loadVectors();
        for (int i = 0; i < numRandom; i++) begin
            randExpA = 1 + ($unsigned($random(seed)) % 254);
            randExpB = 1 + ($unsigned($random(seed)) % 254);
            if ($random(seed) & 1) randExpB = randExpA; // equal exponents for cancellation.
            randA[i] = {1'($random(seed)), 8'(randExpA), 23'($random(seed))};
            randB[i] = {1'($random(seed)), 8'(randExpB), 23'($random(seed))};
        end
        timeoutLimit = (vectors.size() + numRandom) * 8 + 100;
        @(posedge clk);
        while (rst) @(posedge clk);

        // back to back with a free output, so latency and throughput are checked too.
        foreach (vectors[i]) begin
            checkValue({vectors[i].name, " model"}, vectors[i].expected,
                       refAdd(vectors[i].a, vectors[i].b));
            sendPair(vectors[i].name, vectors[i].a, vectors[i].b, vectors[i].expected);
        end
        inValid <= 1'b0;
        waitDrained();

        timingChecks = 1'b0;
        stallOutput <= 1'b1;
        for (int i = 0; i < numRandom; i++) begin
            sendPair($sformatf("random %0d", i), randA[i], randB[i], refAdd(randA[i], randB[i]));
        end
        inValid <= 1'b0;
        waitDrained();
        stallOutput <= 1'b0;

        if (received == vectors.size() + numRandom && DUT.uChecker.failCount == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            stopWithFailure("the number of results does not match the number of operand pairs");
        end
    end

endmodule

//--- verification/fpAdder_checker.sv
`timescale 1ns/100ps

module fpAdderChecker
    import fpuPkg::*;
(
    input logic    clk,
    input logic    rst,
    input logic    outValid,
    input logic    outReady,
    input fpWord_t result
);

    int failCount = 0;

    // pipeline is empty right after reset.
    resetEmpty: assert property (@(posedge clk) rst |=> !outValid)
        else begin
            $error("outValid high in the cycle after reset");
            failCount++;
        end

    // a stalled result must wait unchanged.
    holdStable: assert property (@(posedge clk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(result)))
        else begin
            $error("stalled output changed before it was taken");
            failCount++;
        end

    resultKnown: assert property (@(posedge clk) disable iff (rst)
        outValid |-> !$isunknown(result))
        else begin
            $error("result has unknown bits while outValid is high");
            failCount++;
        end

endmodule

//--- verification/tbClock.sv
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period.
    end

    // reset spans the first five rising edges.
    initial begin
        rst = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
